/* hw/dma_cfg_pkg.sv */
package dma_cfg_pkg;

  localparam int NUM_CHANNELS = 2;
  localparam int CMD_DEPTH    = 8;

  typedef logic [31:0] addr_t;
  typedef logic [23:0] xfer_count_t;
  typedef logic [2:0]  cmd_idx_t;
  typedef logic [11:0] apb_addr_t;
  typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_idx_t;

  localparam addr_t ADDR_STEP = 32'd4;

  // Register map
  localparam apb_addr_t REG_CTRL_BASE   = 12'h000;
  localparam apb_addr_t REG_STATUS_BASE = 12'h010;
  localparam apb_addr_t REG_CMD_BASE    = 12'h100;
  localparam int        CMD_REGION_LSB  = $clog2(CMD_DEPTH * 16);

  // Words inside one 16 byte command entry
  localparam logic [1:0] CMD_WORD_SRC   = 2'd0;
  localparam logic [1:0] CMD_WORD_DST   = 2'd1;
  localparam logic [1:0] CMD_WORD_COUNT = 2'd2;
  localparam logic [1:0] CMD_WORD_FLAGS = 2'd3;

  // Last word holds next above the flags
  typedef struct packed {
    logic src_inc;
    logic src_dec;
    logic dst_inc;
    logic dst_dec;
    logic src_rst;
    logic dst_rst;
    logic stop;
  } cmd_flags_t;

  typedef struct packed {
    addr_t       src;
    addr_t       dst;
    xfer_count_t count;
    cmd_flags_t  flags;
    cmd_idx_t    next;
  } dma_cmd_t;

  // Enable sits in bit 0 of the control word
  typedef struct packed {
    cmd_idx_t start_ip;
    logic     enable;
  } chan_ctrl_t;

  typedef struct packed {
    logic busy;
    logic finished;
  } chan_status_t;

  typedef enum logic [2:0] {
    IDLE,
    SETUP_CHANNEL,
    SETUP_COMMAND,
    ACTIVE,
    END_COMMAND,
    FINISHED
  } chan_state_e;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

/* hw/dma_stream_pkg.sv */
package dma_stream_pkg;
  import dma_cfg_pkg::*;

  typedef logic [31:0] data_t;
  typedef logic [23:0] fifo_size_t;

  // Burst slots inside the mover
  localparam int SIDE_SRC  = 0;
  localparam int SIDE_SNK  = 1;
  localparam int NUM_SIDES = 2;

  typedef struct packed {
    logic       ready;
    fifo_size_t size;
    data_t      data;
  } src_port_in_t;

  typedef struct packed {
    logic  activate;
    logic  strobe;
    addr_t address;
  } src_port_out_t;

  typedef struct packed {
    logic       ready;
    fifo_size_t size;
  } snk_port_in_t;

  typedef struct packed {
    logic  activate;
    logic  strobe;
    data_t data;
    addr_t address;
  } snk_port_out_t;

endpackage

/* hw/dma_apb_regs.sv */
`timescale 1ns/1ps

module dma_apb_regs
  import dma_cfg_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  apb_req_t     i_apb,
  input  chan_status_t i_status [NUM_CHANNELS],
  output apb_rsp_t     o_apb,
  output chan_ctrl_t   o_ctrl [NUM_CHANNELS],
  output dma_cmd_t     o_cmd_table [CMD_DEPTH]
);

  localparam int FLAGS_W = $bits(cmd_flags_t);

  chan_ctrl_t  ctrl_q [NUM_CHANNELS];
  dma_cmd_t    cmd_q [CMD_DEPTH];
  logic        access;
  logic        hit_ctrl;
  logic        hit_status;
  logic        hit_cmd;
  logic        err;
  logic [1:0]  slot;
  chan_idx_t   chan;
  cmd_idx_t    entry;
  logic [31:0] rd_data;

  assign access = i_apb.psel && i_apb.penable;
  assign slot   = i_apb.paddr[3:2];
  assign chan   = slot[$bits(chan_idx_t)-1:0];
  assign entry  = i_apb.paddr[4 +: $bits(cmd_idx_t)];

  // Word aligned offsets only
  always_comb begin
    hit_ctrl   = 1'b0;
    hit_status = 1'b0;
    hit_cmd    = 1'b0;
    if (i_apb.paddr[1:0] == 2'b00) begin
      hit_ctrl   = (i_apb.paddr[11:4] == REG_CTRL_BASE[11:4]) && (slot < 2'(NUM_CHANNELS));
      hit_status = (i_apb.paddr[11:4] == REG_STATUS_BASE[11:4]) && (slot < 2'(NUM_CHANNELS));
      hit_cmd    = i_apb.paddr[11:CMD_REGION_LSB] == REG_CMD_BASE[11:CMD_REGION_LSB];
    end
  end

  // Status is read-only
  assign err = !(hit_ctrl || hit_status || hit_cmd) || (i_apb.pwrite && hit_status);

  assign o_apb.pready  = access;
  assign o_apb.pslverr = access && err;
  assign o_apb.prdata  = rd_data;

  always_comb begin
    rd_data = '0;
    if (hit_ctrl) begin
      rd_data[$bits(chan_ctrl_t)-1:0] = ctrl_q[chan];
    end else if (hit_status) begin
      rd_data[$bits(chan_status_t)-1:0] = i_status[chan];
    end else if (hit_cmd) begin
      case (slot)
        CMD_WORD_SRC: rd_data = cmd_q[entry].src;
        CMD_WORD_DST: rd_data = cmd_q[entry].dst;
        CMD_WORD_COUNT: rd_data[$bits(xfer_count_t)-1:0] = cmd_q[entry].count;
        default: begin
          rd_data[FLAGS_W-1:0]                  = cmd_q[entry].flags;
          rd_data[FLAGS_W +: $bits(cmd_idx_t)] = cmd_q[entry].next;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        ctrl_q[i] <= '0;
      end
    end else if (access && i_apb.pwrite && hit_ctrl) begin
      ctrl_q[chan] <= chan_ctrl_t'(i_apb.pwdata[$bits(chan_ctrl_t)-1:0]);
    end
  end

  // Command table
  always_ff @(posedge clk) begin
    if (access && i_apb.pwrite && hit_cmd) begin
      case (slot)
        CMD_WORD_SRC: cmd_q[entry].src <= i_apb.pwdata;
        CMD_WORD_DST: cmd_q[entry].dst <= i_apb.pwdata;
        CMD_WORD_COUNT: cmd_q[entry].count <= i_apb.pwdata[$bits(xfer_count_t)-1:0];
        default: begin
          cmd_q[entry].flags <= cmd_flags_t'(i_apb.pwdata[FLAGS_W-1:0]);
          cmd_q[entry].next  <= i_apb.pwdata[FLAGS_W +: $bits(cmd_idx_t)];
        end
      endcase
    end
  end

  assign o_ctrl      = ctrl_q;
  assign o_cmd_table = cmd_q;

endmodule

/* hw/dma_channel_seq.sv */
`timescale 1ns/1ps

module dma_channel_seq
  import dma_cfg_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  chan_ctrl_t   i_ctrl,
  input  dma_cmd_t     i_cmd_table [CMD_DEPTH],
  input  logic         i_word_moved,
  output chan_status_t o_status,
  output logic         o_run,
  output addr_t        o_src_addr,
  output addr_t        o_dst_addr,
  output xfer_count_t  o_remaining
);

  chan_state_e state;
  cmd_idx_t    ip;
  dma_cmd_t    cmd;
  addr_t       src_addr;
  addr_t       dst_addr;
  xfer_count_t remaining;

  function automatic addr_t step_addr(addr_t addr, logic inc, logic dec);
    addr_t result;
    result = addr;
    if (inc) begin
      result = addr + ADDR_STEP;
    end else if (dec) begin
      result = addr - ADDR_STEP;
    end
    return result;
  endfunction

  // Command under the instruction pointer
  assign cmd = i_cmd_table[ip];

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      ip        <= '0;
      remaining <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (i_ctrl.enable) begin
            ip    <= i_ctrl.start_ip;
            state <= SETUP_CHANNEL;
          end
        end
        SETUP_CHANNEL: begin
          src_addr <= cmd.src;
          dst_addr <= cmd.dst;
          state    <= i_ctrl.enable ? SETUP_COMMAND : IDLE;
        end
        SETUP_COMMAND: begin
          if (cmd.flags.src_rst) begin
            src_addr <= cmd.src;
          end
          if (cmd.flags.dst_rst) begin
            dst_addr <= cmd.dst;
          end
          remaining <= cmd.count;
          state     <= i_ctrl.enable ? ACTIVE : IDLE;
        end
        ACTIVE: begin
          if (!i_ctrl.enable) begin
            state <= IDLE;
          end else if (remaining == '0) begin
            state <= END_COMMAND;
          end
          // Mover only pulses while running with words left
          if (i_word_moved) begin
            remaining <= remaining - 1'b1;
            src_addr  <= step_addr(src_addr, cmd.flags.src_inc, cmd.flags.src_dec);
            dst_addr  <= step_addr(dst_addr, cmd.flags.dst_inc, cmd.flags.dst_dec);
          end
        end
        END_COMMAND: begin
          if (!i_ctrl.enable) begin
            state <= IDLE;
          end else if (cmd.flags.stop) begin
            state <= FINISHED;
          end else begin
            ip    <= cmd.next;
            state <= SETUP_COMMAND;
          end
        end
        FINISHED: begin
          // Hold until software drops enable
          if (!i_ctrl.enable) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign o_status.busy     = (state != IDLE) && (state != FINISHED);
  assign o_status.finished = state == FINISHED;
  assign o_run             = (state == ACTIVE) && i_ctrl.enable;
  assign o_src_addr        = src_addr;
  assign o_dst_addr        = dst_addr;
  assign o_remaining       = remaining;

endmodule

/* hw/dma_burst_mover.sv */
`timescale 1ns/1ps

module dma_burst_mover
  import dma_cfg_pkg::*;
  import dma_stream_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          i_run,
  input  addr_t         i_src_addr,
  input  addr_t         i_dst_addr,
  input  xfer_count_t   i_remaining,
  input  src_port_in_t  i_src,
  input  snk_port_in_t  i_snk,
  output src_port_out_t o_src,
  output snk_port_out_t o_snk,
  output logic          o_word_moved
);

  logic       ready [NUM_SIDES];
  fifo_size_t size [NUM_SIDES];
  addr_t      addr_in [NUM_SIDES];
  logic       act [NUM_SIDES];
  fifo_size_t cnt [NUM_SIDES];
  addr_t      burst_addr [NUM_SIDES];
  logic       left [NUM_SIDES];
  logic       move;

  assign ready[SIDE_SRC]   = i_src.ready;
  assign ready[SIDE_SNK]   = i_snk.ready;
  assign size[SIDE_SRC]    = i_src.size;
  assign size[SIDE_SNK]    = i_snk.size;
  assign addr_in[SIDE_SRC] = i_src_addr;
  assign addr_in[SIDE_SNK] = i_dst_addr;

  // Words still to pop or room still to fill
  always_comb begin
    for (int s = 0; s < NUM_SIDES; s++) begin
      left[s] = act[s] && (cnt[s] < size[s]);
    end
  end

  assign move = i_run && left[SIDE_SRC] && left[SIDE_SNK] && (i_remaining != '0);

  // Partial bursts are released as soon as the run drops
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < NUM_SIDES; s++) begin
        act[s] <= 1'b0;
        cnt[s] <= '0;
      end
    end else begin
      for (int s = 0; s < NUM_SIDES; s++) begin
        if (!i_run) begin
          act[s] <= 1'b0;
        end else if (!act[s]) begin
          if (ready[s]) begin
            act[s] <= 1'b1;
            cnt[s] <= '0;
          end
        end else if (move) begin
          cnt[s] <= cnt[s] + 1'b1;
        end else if (!left[s]) begin
          act[s] <= 1'b0;
        end
      end
    end
  end

  // Burst address taken at activation
  always_ff @(posedge clk) begin
    for (int s = 0; s < NUM_SIDES; s++) begin
      if (i_run && !act[s] && ready[s]) begin
        burst_addr[s] <= addr_in[s];
      end
    end
  end

  assign o_src.activate = act[SIDE_SRC];
  assign o_src.strobe   = move;
  assign o_src.address  = burst_addr[SIDE_SRC];
  assign o_snk.activate = act[SIDE_SNK];
  assign o_snk.strobe   = move;
  assign o_snk.data     = i_src.data;
  assign o_snk.address  = burst_addr[SIDE_SNK];
  assign o_word_moved   = move;

endmodule

/* hw/dma_top.sv */
`timescale 1ns/1ps

module dma_top
  import dma_cfg_pkg::*;
  import dma_stream_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  apb_req_t      i_apb,
  input  src_port_in_t  i_src [NUM_CHANNELS],
  input  snk_port_in_t  i_snk [NUM_CHANNELS],
  output apb_rsp_t      o_apb,
  output src_port_out_t o_src [NUM_CHANNELS],
  output snk_port_out_t o_snk [NUM_CHANNELS],
  output logic          o_interrupt
);

  chan_ctrl_t   ctrl [NUM_CHANNELS];
  chan_status_t status [NUM_CHANNELS];
  dma_cmd_t     cmd_table [CMD_DEPTH];
  logic         run [NUM_CHANNELS];
  addr_t        src_addr [NUM_CHANNELS];
  addr_t        dst_addr [NUM_CHANNELS];
  xfer_count_t  remaining [NUM_CHANNELS];
  logic         word_moved [NUM_CHANNELS];

  dma_apb_regs i_regs (
    .clk         (clk),
    .rst         (rst),
    .i_apb       (i_apb),
    .i_status    (status),
    .o_apb       (o_apb),
    .o_ctrl      (ctrl),
    .o_cmd_table (cmd_table)
  );

  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    dma_channel_seq i_seq (
      .clk          (clk),
      .rst          (rst),
      .i_ctrl       (ctrl[c]),
      .i_cmd_table  (cmd_table),
      .i_word_moved (word_moved[c]),
      .o_status     (status[c]),
      .o_run        (run[c]),
      .o_src_addr   (src_addr[c]),
      .o_dst_addr   (dst_addr[c]),
      .o_remaining  (remaining[c])
    );

    dma_burst_mover i_mover (
      .clk          (clk),
      .rst          (rst),
      .i_run        (run[c]),
      .i_src_addr   (src_addr[c]),
      .i_dst_addr   (dst_addr[c]),
      .i_remaining  (remaining[c]),
      .i_src        (i_src[c]),
      .i_snk        (i_snk[c]),
      .o_src        (o_src[c]),
      .o_snk        (o_snk[c]),
      .o_word_moved (word_moved[c])
    );
  end

  // Any finished channel interrupts
  always_comb begin
    o_interrupt = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      o_interrupt = o_interrupt | status[c].finished;
    end
  end

endmodule

/* sim/dma_sva.sv */
`timescale 1ns/1ps

module dma_sva
  import dma_cfg_pkg::*;
  import dma_stream_pkg::*;
(
  input logic          clk,
  input logic          rst,
  input src_port_out_t i_src [NUM_CHANNELS],
  input snk_port_out_t i_snk [NUM_CHANNELS],
  input chan_ctrl_t    i_ctrl [NUM_CHANNELS],
  input chan_status_t  i_status [NUM_CHANNELS]
);

  // Mover ports and sequencer status of each channel
  for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
    a_src_strobe: assert property (@(posedge clk) disable iff (rst)
      i_src[c].strobe |-> i_src[c].activate)
      else $error("Source strobe without activate on channel %0d", c);

    a_snk_strobe: assert property (@(posedge clk) disable iff (rst)
      i_snk[c].strobe |-> i_snk[c].activate)
      else $error("Sink strobe without activate on channel %0d", c);

    a_strobe_pair: assert property (@(posedge clk) disable iff (rst)
      i_src[c].strobe == i_snk[c].strobe)
      else $error("Source and sink strobes differ on channel %0d", c);

    // FINISHED is left only once enable is low
    a_finished_hold: assert property (@(posedge clk) disable iff (rst)
      (i_status[c].finished && i_ctrl[c].enable) |=> i_status[c].finished)
      else $error("Channel %0d left FINISHED with enable set", c);
  end

endmodule

bind dma_top dma_sva i_sva (
  .clk      (clk),
  .rst      (rst),
  .i_src    (o_src),
  .i_snk    (o_snk),
  .i_ctrl   (ctrl),
  .i_status (status)
);

/* sim/dma_checker.sv */
`timescale 1ns/1ps

module dma_checker
  import dma_cfg_pkg::*;
  import dma_stream_pkg::*;
(
  input logic          clk,
  input logic          rst,
  input apb_req_t      i_apb,
  input apb_rsp_t      i_rsp,
  input src_port_out_t i_src [NUM_CHANNELS],
  input snk_port_out_t i_snk [NUM_CHANNELS],
  input logic          i_interrupt
);

  localparam int MAX_WORDS = 16;
  localparam int MAX_CMDS  = 4;

  logic [31:0] exp_word [NUM_CHANNELS][MAX_WORDS];
  addr_t       cmd_src_base [NUM_CHANNELS][MAX_CMDS];
  int          cmd_src_step [NUM_CHANNELS][MAX_CMDS];
  addr_t       cmd_base [NUM_CHANNELS][MAX_CMDS];
  int          cmd_step [NUM_CHANNELS][MAX_CMDS];
  int          cmd_cnt [NUM_CHANNELS][MAX_CMDS];
  int          exp_len [NUM_CHANNELS];
  int          got [NUM_CHANNELS];
  int          ncmd [NUM_CHANNELS];
  int          cur [NUM_CHANNELS];
  int          k [NUM_CHANNELS];
  logic        src_act_q [NUM_CHANNELS];
  logic        snk_act_q [NUM_CHANNELS];
  logic [31:0] last_rdata;
  logic        last_err;
  string       test_name;
  int          error_count = 0;
  int          test_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error in %s: %s", test_name, msg);
    error_count++;
    test_errors++;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("Test %s: ok", test_name);
      tests_passed++;
    end else begin
      $display("Test %s: %0d errors", test_name, test_errors);
      tests_failed++;
    end
  endtask

  task automatic clear_channel(input int c);
    exp_len[c] = 0;
    got[c]     = 0;
    ncmd[c]    = 0;
    cur[c]     = 0;
    k[c]       = 0;
  endtask

  task automatic add_cmd(input int c, input addr_t src_base, input int src_step,
                         input addr_t base, input int step, input int cnt);
    if (ncmd[c] < MAX_CMDS) begin
      cmd_src_base[c][ncmd[c]] = src_base;
      cmd_src_step[c][ncmd[c]] = src_step;
      cmd_base[c][ncmd[c]]     = base;
      cmd_step[c][ncmd[c]]     = step;
      cmd_cnt[c][ncmd[c]]      = cnt;
      ncmd[c]++;
    end
  endtask

  task automatic add_word(input int c, input logic [31:0] w);
    if (exp_len[c] < MAX_WORDS) begin
      exp_word[c][exp_len[c]] = w;
      exp_len[c]++;
    end
  endtask

  // An aborted run may stop early but never deliver more
  task automatic check_count(input int c, input int total, input logic exact);
    if (exact) begin
      check_value($sformatf("channel %0d word count", c), 32'(total), 32'(got[c]));
    end else if (got[c] > total) begin
      report_failure($sformatf("channel %0d delivered %0d words, more than %0d",
                               c, got[c], total));
    end
  endtask

  task automatic check_idle(input int c);
    check_value($sformatf("channel %0d source activate", c), 32'h0, 32'(i_src[c].activate));
    check_value($sformatf("channel %0d sink activate", c), 32'h0, 32'(i_snk[c].activate));
  endtask

  task automatic check_interrupt(input logic exp);
    check_value("interrupt", 32'(exp), 32'(i_interrupt));
  endtask

  task automatic print_summary();
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_passed + tests_failed, tests_passed, tests_failed, error_count);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        src_act_q[c] = 1'b0;
        snk_act_q[c] = 1'b0;
      end
    end else begin
      if (i_apb.psel && i_apb.penable) begin
        if (!i_rsp.pready) begin
          report_failure("pready low in the APB access phase");
        end
        last_rdata = i_rsp.prdata;
        last_err   = i_rsp.pslverr;
      end
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        // Addresses are checked before this cycle's word is counted
        if (i_src[c].activate && !src_act_q[c] && cur[c] < ncmd[c]) begin
          check_value($sformatf("channel %0d source burst address", c),
                      cmd_src_base[c][cur[c]] + addr_t'(cmd_src_step[c][cur[c]] * k[c]),
                      i_src[c].address);
        end
        if (i_snk[c].activate && !snk_act_q[c] && cur[c] < ncmd[c]) begin
          check_value($sformatf("channel %0d sink burst address", c),
                      cmd_base[c][cur[c]] + addr_t'(cmd_step[c][cur[c]] * k[c]),
                      i_snk[c].address);
        end
        if (i_snk[c].strobe) begin
          if (got[c] < exp_len[c]) begin
            check_value($sformatf("channel %0d word %0d", c, got[c]),
                        exp_word[c][got[c]], i_snk[c].data);
          end else begin
            report_failure($sformatf("channel %0d wrote an unexpected extra word", c));
          end
          got[c]++;
          k[c]++;
          if (cur[c] < ncmd[c] && k[c] == cmd_cnt[c][cur[c]]) begin
            cur[c]++;
            k[c] = 0;
          end
        end
        src_act_q[c] = i_src[c].activate;
        snk_act_q[c] = i_snk[c].activate;
      end
    end
  end

endmodule

/* sim/dma_tb.sv */
`timescale 1ns/1ps

module dma_tb
  import dma_cfg_pkg::*;
  import dma_stream_pkg::*;
;

  localparam int VEC_SRC    = 32;
  localparam int VEC_TOTALS = 64;
  localparam int NUM_XFERS  = 5;

  logic          clk;
  logic          rst;
  apb_req_t      apb_req;
  apb_rsp_t      apb_rsp;
  src_port_in_t  src_in [NUM_CHANNELS];
  snk_port_in_t  snk_in [NUM_CHANNELS];
  src_port_out_t src_out [NUM_CHANNELS];
  snk_port_out_t snk_out [NUM_CHANNELS];
  logic          irq;
  logic [31:0]   vec [0:79];
  int            src_ptr [NUM_CHANNELS];
  logic          ptr_clear;
  logic          random_ready;
  int            seed = 32'h537dc070;
  int            cycles = 0;
  int            limit = 0;

  dma_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .i_apb       (apb_req),
    .i_src       (src_in),
    .i_snk       (snk_in),
    .o_apb       (apb_rsp),
    .o_src       (src_out),
    .o_snk       (snk_out),
    .o_interrupt (irq)
  );

  dma_checker u_check (
    .clk         (clk),
    .rst         (rst),
    .i_apb       (apb_req),
    .i_rsp       (apb_rsp),
    .i_src       (src_out),
    .i_snk       (snk_out),
    .i_interrupt (irq)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Source read pointer advances on each strobe
  always @(posedge clk) begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (rst || ptr_clear) begin
        src_ptr[c] = 0;
      end else if (src_out[c].strobe) begin
        src_ptr[c] = src_ptr[c] + 1;
      end
    end
  end

  always @(negedge clk) begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      src_in[c].data  = vec[VEC_SRC + 16 * c + (src_ptr[c] % 16)];
      src_in[c].ready = 1'b1;
      src_in[c].size  = 24'd4;
      snk_in[c].ready = random_ready ? (($random(seed) & 3) != 0) : 1'b1;
      snk_in[c].size  = 24'd3;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, the DUT did not complete", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic apb_addr_t ctrl_addr(input int c);
    return REG_CTRL_BASE + apb_addr_t'(4 * c);
  endfunction

  function automatic apb_addr_t status_addr(input int c);
    return REG_STATUS_BASE + apb_addr_t'(4 * c);
  endfunction

  task automatic apb_cycle(input logic write, input apb_addr_t addr, input logic [31:0] wdata);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input logic [31:0] data, input logic exp_err);
    apb_cycle(1'b1, addr, data);
    u_check.check_value($sformatf("pslverr on write to %h", addr), 32'(exp_err),
                        32'(u_check.last_err));
  endtask

  task automatic expect_read(input apb_addr_t addr, input logic [31:0] exp, input logic exp_err);
    apb_cycle(1'b0, addr, 32'h0);
    u_check.check_value($sformatf("pslverr on read of %h", addr), 32'(exp_err),
                        32'(u_check.last_err));
    if (!exp_err) begin
      u_check.check_value($sformatf("read of %h", addr), exp, u_check.last_rdata);
    end
  endtask

  task automatic wait_finished(input int c);
    logic [31:0] data;
    data = 32'h0;
    while (data[0] !== 1'b1) begin
      apb_cycle(1'b0, status_addr(c), 32'h0);
      data = u_check.last_rdata;
    end
  endtask

  task automatic restart_sources();
    ptr_clear = 1'b1;
    @(negedge clk);
    ptr_clear = 1'b0;
  endtask

  // Follows next from ip and builds the expected words and burst bases
  task automatic expect_chain(input int c, input int ip);
    logic [31:0] flags;
    addr_t       src_base;
    addr_t       src_now;
    int          src_step;
    addr_t       base;
    addr_t       dst_now;
    int          step;
    int          cnt;
    int          widx;
    u_check.clear_channel(c);
    widx    = 0;
    src_now = '0;
    dst_now = '0;
    for (int i = 0; i < CMD_DEPTH; i++) begin
      flags    = vec[ip * 4 + 3];
      cnt      = int'(vec[ip * 4 + 2]);
      src_base = (i == 0 || flags[2]) ? vec[ip * 4] : src_now;
      src_step = flags[6] ? 4 : (flags[5] ? -4 : 0);
      base     = (i == 0 || flags[1]) ? vec[ip * 4 + 1] : dst_now;
      step     = flags[4] ? 4 : (flags[3] ? -4 : 0);
      u_check.add_cmd(c, src_base, src_step, base, step, cnt);
      for (int n = 0; n < cnt; n++) begin
        u_check.add_word(c, vec[VEC_SRC + 16 * c + (widx % 16)]);
        widx++;
      end
      src_now = src_base + addr_t'(src_step * cnt);
      dst_now = base + addr_t'(step * cnt);
      if (flags[0]) begin
        break;
      end
      ip = int'(flags[9:7]);
    end
  endtask

  initial begin
    logic [31:0] mask;
    int          total;
    $readmemh("sim/dma_vectors.hex", vec);
    rst          = 1'b1;
    apb_req      = '0;
    ptr_clear    = 1'b0;
    random_ready = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      src_in[c] = '0;
      snk_in[c] = '0;
    end
    total = 0;
    for (int i = 0; i < NUM_XFERS; i++) begin
      total = total + int'(vec[VEC_TOTALS + i]);
    end
    limit = total * 8 + 200;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    u_check.start_test("reset_and_table");
    expect_read(status_addr(0), 32'h0, 1'b0);
    expect_read(status_addr(1), 32'h0, 1'b0);
    u_check.check_interrupt(1'b0);
    for (int e = 0; e < CMD_DEPTH; e++) begin
      for (int w = 0; w < 4; w++) begin
        write_reg(REG_CMD_BASE + apb_addr_t'(16 * e + 4 * w), vec[e * 4 + w], 1'b0);
      end
    end
    for (int e = 0; e < CMD_DEPTH; e++) begin
      for (int w = 0; w < 4; w++) begin
        mask = (w == 2) ? 32'h00ff_ffff : ((w == 3) ? 32'h0000_03ff : 32'hffff_ffff);
        expect_read(REG_CMD_BASE + apb_addr_t'(16 * e + 4 * w), vec[e * 4 + w] & mask, 1'b0);
      end
    end
    u_check.finish_test();

    u_check.start_test("single_increment");
    restart_sources();
    expect_chain(0, 0);
    write_reg(ctrl_addr(0), 32'h1, 1'b0);
    wait_finished(0);
    u_check.check_count(0, int'(vec[VEC_TOTALS]), 1'b1);
    write_reg(ctrl_addr(0), 32'h0, 1'b0);
    u_check.finish_test();

    u_check.start_test("chain_decrement");
    restart_sources();
    expect_chain(0, 1);
    write_reg(ctrl_addr(0), 32'h3, 1'b0);
    wait_finished(0);
    u_check.check_count(0, int'(vec[VEC_TOTALS + 1]), 1'b1);
    u_check.check_interrupt(1'b1);
    expect_read(status_addr(0), 32'h1, 1'b0);
    write_reg(ctrl_addr(0), 32'h0, 1'b0);
    expect_read(status_addr(0), 32'h0, 1'b0);
    u_check.check_interrupt(1'b0);
    u_check.finish_test();

    u_check.start_test("concurrent_random");
    random_ready = 1'b1;
    restart_sources();
    expect_chain(0, 0);
    expect_chain(1, 3);
    write_reg(ctrl_addr(1), 32'h7, 1'b0);
    write_reg(ctrl_addr(0), 32'h1, 1'b0);
    wait_finished(0);
    wait_finished(1);
    u_check.check_count(0, int'(vec[VEC_TOTALS + 2]), 1'b1);
    u_check.check_count(1, int'(vec[VEC_TOTALS + 3]), 1'b1);
    write_reg(ctrl_addr(0), 32'h0, 1'b0);
    write_reg(ctrl_addr(1), 32'h0, 1'b0);
    random_ready = 1'b0;
    u_check.finish_test();

    u_check.start_test("apb_errors");
    expect_read(12'h020, 32'h0, 1'b1);
    write_reg(status_addr(0), 32'h3, 1'b1);
    write_reg(12'h180, 32'hdead_beef, 1'b1);
    write_reg(12'h008, 32'h1, 1'b1);
    write_reg(12'h002, 32'h1, 1'b1);
    expect_read(ctrl_addr(0), 32'h0, 1'b0);
    expect_read(status_addr(0), 32'h0, 1'b0);
    expect_read(REG_CMD_BASE, vec[0], 1'b0);
    u_check.finish_test();

    u_check.start_test("abort");
    restart_sources();
    expect_chain(0, 4);
    write_reg(ctrl_addr(0), 32'h9, 1'b0);
    while (u_check.got[0] < 4) begin
      @(negedge clk);
    end
    write_reg(ctrl_addr(0), 32'h0, 1'b0);
    repeat (2) @(negedge clk);
    u_check.check_idle(0);
    expect_read(status_addr(0), 32'h0, 1'b0);
    u_check.check_count(0, int'(vec[VEC_TOTALS + 4]), 1'b0);
    u_check.finish_test();

    u_check.print_summary();
    if (u_check.error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* sim/dma_vectors.hex */
// Command table at 00: src dst count flags_next, two entries per line
// Source words per channel at 20 and 30, words per transfer at 40
@00
00001000 00004000 00000006 00000057 00001100 00002000 00000003 0000014E
00001200 00003000 00000004 0000004F 00001300 00006000 00000005 00000057
00001400 00007000 0000000C 00000057 00001500 00008000 00000001 00000281
00001600 00009000 00000002 00000302 00001700 0000A000 00000003 00000383
@20
A5A50001 5A5A0002 C3C30003 3C3C0004 0F0F0005 F0F00006 12340007 56780008
9ABC0009 DEF0000A 1111000B 2222000C 3333000D 4444000E 5555000F 66660010
@30
B0000101 B0000202 B0000303 B0000404 B0000505 B0000606 B0000707 B0000808
B0000909 B0000A0A B0000B0B B0000C0C B0000D0D B0000E0E B0000F0F B0001010
@40
00000006 00000007 00000006 00000005 0000000C

/* project.f */
hw/dma_cfg_pkg.sv
hw/dma_stream_pkg.sv
hw/dma_apb_regs.sv
hw/dma_channel_seq.sv
hw/dma_burst_mover.sv
hw/dma_top.sv
sim/dma_sva.sv
sim/dma_checker.sv
sim/dma_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module dma_tb \
  -Mdir obj_dir -o dma_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dma_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
